// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sparse_chunk
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+.
sparse_chunk_pkg.sv
data_chunk.sv
data_addr_cal.sv
nz_scan.sv
data_chunk_top.sv
sparse_chunk_top.sv
tb_sparse_chunk.sv

// File: data_addr_cal.sv
`timescale 1ns/1ps
`default_nettype none
`include "sparse_chunk_settings.svh"

module data_addr_cal (
	 input  wire logic                         clk_i
	,input  wire logic                         arst_n_i
	,input  wire logic                         chunk_start_i
	,input  wire logic [`PREFIX_SUM_SIZE-1:0]  sparsemap_i
	,input  wire logic [`MATCH_W-1:0]          match_addr_i
	,input  wire logic                         word_end_i
	,output logic      [`POS_W-1:0]            rd_dat_addr_o
);

	localparam int PTR_W = `POS_W;
	localparam int SUM_W = $clog2(`PREFIX_SUM_SIZE) + 1;

	// Nonzeros in all earlier words of the chunk
	logic [PTR_W-1:0]            base_q;
	logic [`PREFIX_SUM_SIZE-1:0] below_mask;
	logic [SUM_W-1:0]            word_sum;
	logic [SUM_W-1:0]            prefix_sum;

	// Bits strictly below the matched one
	assign below_mask = (`PREFIX_SUM_SIZE'(1) << match_addr_i) - `PREFIX_SUM_SIZE'(1);

	////////////////////////////////////////
	// Popcounts of the current word
	////////////////////////////////////////

	always_comb begin
		word_sum   = '0;
		prefix_sum = '0;
		for (int i = 0; i < `PREFIX_SUM_SIZE; i++) begin
			word_sum   = word_sum + SUM_W'(sparsemap_i[i]);
			prefix_sum = prefix_sum + SUM_W'(sparsemap_i[i] & below_mask[i]);
		end
	end

	// Base moves forward once a word is finished
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			base_q <= '0;
		end else if (chunk_start_i) begin
			base_q <= '0;
		end else if (word_end_i) begin
			base_q <= base_q + PTR_W'(word_sum);
		end
	end

	// Rank of the match gives its compacted address
	assign rd_dat_addr_o = base_q + PTR_W'(prefix_sum);

endmodule

`default_nettype wire

// File: data_chunk.sv
`timescale 1ns/1ps
`default_nettype none
`include "sparse_chunk_settings.svh"

module data_chunk
	import sparse_chunk_pkg::*;
(
	 input  wire logic                         clk_i
	,input  wire logic                         arst_n_i
	,input  wire chunk_wr_t                    wr_i
	,input  wire logic                         wr_valid_i
	,input  wire logic [`POS_W-1:0]            rd_addr_i
	,output logic      [7:0]                   rd_data_o
	,input  wire logic [`SMAP_ADDR_W-1:0]      rd_smap_addr_i
	,output logic      [`PREFIX_SUM_SIZE-1:0]  rd_smap_o
);

	localparam int PTR_W = `POS_W;
	localparam int CNT_W = $clog2(`BUS_SIZE) + 1;

	// Whole chunk sparsemap, one slice per write beat
	logic [`MEM_SIZE-1:0]      smap_q;
	// Nonzero bytes, packed from address 0 upward
	logic [`MEM_SIZE-1:0][7:0] data_q;

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] wr_base;
	logic [CNT_W-1:0] wr_cnt;

	// Nonzero lanes in this beat
	always_comb begin
		wr_cnt = '0;
		for (int i = 0; i < `BUS_SIZE; i++) begin
			wr_cnt = wr_cnt + CNT_W'(wr_i.sparsemap[i]);
		end
	end

	// First beat of a chunk restarts packing at 0
	assign wr_base = (wr_i.word_count == '0) ? '0 : wr_ptr_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
		end else if (wr_valid_i) begin
			wr_ptr_q <= wr_base + PTR_W'(wr_cnt);
		end
	end

	////////////////////////////////////////
	// Storage arrays
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			smap_q[wr_i.word_count*`BUS_SIZE +: `BUS_SIZE] <= wr_i.sparsemap;
			// Lanes above the popcount carry nothing
			for (int i = 0; i < `BUS_SIZE; i++) begin
				if (CNT_W'(i) < wr_cnt) begin
					data_q[wr_base + PTR_W'(i)] <= wr_i.nonzero_data[i];
				end
			end
		end
	end

	// Both reads are combinational
	assign rd_data_o = data_q[rd_addr_i];
	assign rd_smap_o = smap_q[rd_smap_addr_i*`PREFIX_SUM_SIZE +: `PREFIX_SUM_SIZE];

endmodule

`default_nettype wire

// File: data_chunk_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sparse_chunk_settings.svh"

module data_chunk_top
	import sparse_chunk_pkg::*;
(
	 input  wire logic                         clk_i
	,input  wire logic                         arst_n_i
	,input  wire chunk_wr_t                    wr_i
	,input  wire logic                         wr_valid_i
	,input  wire logic                         wr_sel_i
	,input  wire logic                         rd_sel_i
	,input  wire logic                         chunk_start_i
	,input  wire logic [`SMAP_ADDR_W-1:0]      smap_addr_i
	,input  wire logic [`MATCH_W-1:0]          match_addr_i
	,input  wire logic                         match_valid_i
	,input  wire logic                         word_end_i
	,output logic      [`PREFIX_SUM_SIZE-1:0]  sparsemap_o
	,output nz_elem_t                          rd_elem_o
	,output logic                              rd_valid_o
);

	logic [1:0]                        bank_wr_val;
	logic [1:0][7:0]                   bank_rd_data;
	logic [1:0][`PREFIX_SUM_SIZE-1:0]  bank_smap;
	logic [`POS_W-1:0]                 rd_dat_addr;
	logic [7:0]                        rd_data;

	// Write beat goes only to the selected bank
	assign bank_wr_val[0] = wr_valid_i & ~wr_sel_i;
	assign bank_wr_val[1] = wr_valid_i &  wr_sel_i;

	////////////////////////////////////////
	// Ping-pong banks
	////////////////////////////////////////

	for (genvar b = 0; b < 2; b++) begin : g_bank
		data_chunk u_data_chunk (
			 .clk_i          (clk_i)
			,.arst_n_i       (arst_n_i)
			,.wr_i           (wr_i)
			,.wr_valid_i     (bank_wr_val[b])
			,.rd_addr_i      (rd_dat_addr)
			,.rd_data_o      (bank_rd_data[b])
			,.rd_smap_addr_i (smap_addr_i)
			,.rd_smap_o      (bank_smap[b])
		);
	end

	// Read side follows rd_sel_i for the whole scan
	assign sparsemap_o = bank_smap[rd_sel_i];
	assign rd_data     = bank_rd_data[rd_sel_i];

	data_addr_cal u_data_addr_cal (
		 .clk_i         (clk_i)
		,.arst_n_i      (arst_n_i)
		,.chunk_start_i (chunk_start_i)
		,.sparsemap_i   (sparsemap_o)
		,.match_addr_i  (match_addr_i)
		,.word_end_i    (word_end_i)
		,.rd_dat_addr_o (rd_dat_addr)
	);

	// Dense position is word index over bit index
	always_ff @(posedge clk_i) begin
		if (match_valid_i) begin
			rd_elem_o.pos  <= {smap_addr_i, match_addr_i};
			rd_elem_o.data <= rd_data;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_valid_o <= 1'b0;
		end else begin
			rd_valid_o <= match_valid_i;
		end
	end

endmodule

`default_nettype wire

// File: nz_scan.sv
`timescale 1ns/1ps
`default_nettype none
`include "sparse_chunk_settings.svh"

module nz_scan
	import sparse_chunk_pkg::*;
(
	 input  wire logic                         clk_i
	,input  wire logic                         arst_n_i
	,input  wire logic                         chunk_start_i
	,input  wire logic [`PREFIX_SUM_SIZE-1:0]  sparsemap_i
	,output logic      [`SMAP_ADDR_W-1:0]      smap_addr_o
	,output logic      [`MATCH_W-1:0]          match_addr_o
	,output logic                              match_valid_o
	,output logic                              word_end_o
	,output logic                              done_o
);

	localparam int SMAP_W  = `PREFIX_SUM_SIZE;
	localparam int ADDR_W  = `SMAP_ADDR_W;
	localparam int MATCH_W = `MATCH_W;
	localparam logic [ADDR_W-1:0] LAST_WORD = ADDR_W'(`SMAP_WORD_NUM - 1);

	scan_state_e state_q;
	scan_state_e state_d;

	logic [ADDR_W-1:0] word_q;
	// Working copy with already issued bits cleared
	logic [SMAP_W-1:0] work_q;
	// Word just advanced, copy not loaded yet
	logic              fresh_q;

	logic [SMAP_W-1:0] cur_word;
	logic [SMAP_W-1:0] rest_word;
	logic              last_word;

	assign cur_word    = fresh_q ? sparsemap_i : work_q;
	// Lowest set bit removed
	assign rest_word   = cur_word & (cur_word - SMAP_W'(1));
	assign last_word   = (word_q == LAST_WORD);
	assign smap_addr_o = word_q;

	// Priority encoder, lowest set bit wins
	always_comb begin
		match_addr_o = '0;
		for (int i = SMAP_W - 1; i >= 0; i--) begin
			if (cur_word[i]) begin
				match_addr_o = MATCH_W'(i);
			end
		end
	end

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_comb begin
		state_d       = state_q;
		match_valid_o = 1'b0;
		word_end_o    = 1'b0;
		done_o        = 1'b0;
		case (state_q)
			SCAN_IDLE: begin
				if (chunk_start_i) begin
					state_d = SCAN_LOAD;
				end
			end
			SCAN_LOAD: begin
				state_d = SCAN_EMIT;
			end
			SCAN_EMIT: begin
				match_valid_o = |cur_word;
				// Also true for an empty word, which takes one cycle
				word_end_o    = (rest_word == '0);
				if (word_end_o && last_word) begin
					state_d = SCAN_DONE;
				end
			end
			SCAN_DONE: begin
				done_o  = 1'b1;
				state_d = SCAN_IDLE;
			end
			default: begin
				state_d = SCAN_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= SCAN_IDLE;
			word_q  <= '0;
			work_q  <= '0;
			fresh_q <= 1'b0;
		end else begin
			state_q <= state_d;
			case (state_q)
				SCAN_LOAD: begin
					work_q  <= sparsemap_i;
					fresh_q <= 1'b0;
				end
				SCAN_EMIT: begin
					work_q  <= rest_word;
					fresh_q <= 1'b0;
					// Next word is taken straight from the bank
					if (word_end_o && !last_word) begin
						word_q  <= word_q + ADDR_W'(1);
						fresh_q <= 1'b1;
					end
				end
				SCAN_DONE: begin
					word_q <= '0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sparse_chunk_pkg.sv
`default_nettype none
`include "sparse_chunk_settings.svh"

package sparse_chunk_pkg;

	// One write beat, nonzero bytes packed into the low lanes
	typedef struct packed {
		logic [`BUS_SIZE-1:0]      sparsemap;
		logic [`BUS_SIZE-1:0][7:0] nonzero_data;
		logic [`WR_CNT_W-1:0]      word_count;
	} chunk_wr_t;

	// One element of the compressed read stream
	typedef struct packed {
		logic [`POS_W-1:0] pos;
		logic [7:0]        data;
	} nz_elem_t;

	// Sparsemap scanner states
	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_LOAD,
		SCAN_EMIT,
		SCAN_DONE
	} scan_state_e;

endpackage

`default_nettype wire

// File: sparse_chunk_settings.svh
`ifndef SPARSE_CHUNK_SETTINGS_SVH
`define SPARSE_CHUNK_SETTINGS_SVH

////////////////////////////////////////
// Chunk geometry
////////////////////////////////////////

// Dense byte positions per chunk
`define MEM_SIZE 64
// Positions delivered per write beat
`define BUS_SIZE 8
// Sparsemap bits handled per scan word
`define PREFIX_SUM_SIZE 16

////////////////////////////////////////
// Derived counts and index widths
////////////////////////////////////////

`define WR_CYC_NUM (`MEM_SIZE / `BUS_SIZE)
`define SMAP_WORD_NUM (`MEM_SIZE / `PREFIX_SUM_SIZE)

`define POS_W ($clog2(`MEM_SIZE))
`define WR_CNT_W ($clog2(`WR_CYC_NUM))
`define SMAP_ADDR_W ($clog2(`SMAP_WORD_NUM))
`define MATCH_W ($clog2(`PREFIX_SUM_SIZE))

`endif

// File: sparse_chunk_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sparse_chunk_settings.svh"

module sparse_chunk_top
	import sparse_chunk_pkg::*;
(
	 input  wire logic      clk_i
	,input  wire logic      arst_n_i
	,input  wire chunk_wr_t wr_i
	,input  wire logic      wr_valid_i
	,input  wire logic      wr_sel_i
	,input  wire logic      rd_sel_i
	,input  wire logic      chunk_start_i
	,output nz_elem_t       rd_elem_o
	,output logic           rd_valid_o
	,output logic           rd_done_o
);

	logic [`SMAP_ADDR_W-1:0]     smap_addr;
	logic [`MATCH_W-1:0]         match_addr;
	logic [`PREFIX_SUM_SIZE-1:0] sparsemap;
	logic                        match_valid;
	logic                        word_end;
	logic                        scan_done;
	logic                        scan_start;
	logic                        scan_busy_q;

	// Start seen mid-scan is dropped by both the scanner and the address base
	assign scan_start = chunk_start_i & ~scan_busy_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scan_busy_q <= 1'b0;
			rd_done_o   <= 1'b0;
		end else begin
			// One cycle late, so done lands after the last element
			rd_done_o <= scan_done;
			if (scan_start) begin
				scan_busy_q <= 1'b1;
			end else if (scan_done) begin
				scan_busy_q <= 1'b0;
			end
		end
	end

	nz_scan u_nz_scan (
		 .clk_i         (clk_i)
		,.arst_n_i      (arst_n_i)
		,.chunk_start_i (scan_start)
		,.sparsemap_i   (sparsemap)
		,.smap_addr_o   (smap_addr)
		,.match_addr_o  (match_addr)
		,.match_valid_o (match_valid)
		,.word_end_o    (word_end)
		,.done_o        (scan_done)
	);

	data_chunk_top u_data_chunk_top (
		 .clk_i         (clk_i)
		,.arst_n_i      (arst_n_i)
		,.wr_i          (wr_i)
		,.wr_valid_i    (wr_valid_i)
		,.wr_sel_i      (wr_sel_i)
		,.rd_sel_i      (rd_sel_i)
		,.chunk_start_i (scan_start)
		,.smap_addr_i   (smap_addr)
		,.match_addr_i  (match_addr)
		,.match_valid_i (match_valid)
		,.word_end_i    (word_end)
		,.sparsemap_o   (sparsemap)
		,.rd_elem_o     (rd_elem_o)
		,.rd_valid_o    (rd_valid_o)
	);

endmodule

`default_nettype wire

// File: tb_sparse_chunk.sv
`timescale 1ns/1ps
`default_nettype none
`include "sparse_chunk_settings.svh"

module tb_sparse_chunk
	import sparse_chunk_pkg::*;
;

	// Idle check plus one per chunk scan
	localparam int NUM_TESTS  = 16;
	localparam int CLK_NS     = 8;
	localparam int TIMEOUT_NS = NUM_TESTS * 200 * CLK_NS;
	localparam int SCAN_LIMIT = `MEM_SIZE + 4 * `SMAP_WORD_NUM + 16;

	logic      clk;
	logic      arst_n;
	chunk_wr_t wr;
	logic      wr_valid;
	logic      wr_sel;
	logic      rd_sel;
	logic      chunk_start;
	nz_elem_t  rd_elem;
	logic      rd_valid;
	logic      rd_done;

	// Dense model of both banks
	logic [7:0]  mem [2][`MEM_SIZE];
	nz_elem_t    exp_q[$];
	int          got_cnt;
	int          done_cnt;

	sparse_chunk_top dut (
		 .clk_i         (clk)
		,.arst_n_i      (arst_n)
		,.wr_i          (wr)
		,.wr_valid_i    (wr_valid)
		,.wr_sel_i      (wr_sel)
		,.rd_sel_i      (rd_sel)
		,.chunk_start_i (chunk_start)
		,.rd_elem_o     (rd_elem)
		,.rd_valid_o    (rd_valid)
		,.rd_done_o     (rd_done)
	);

	always #(CLK_NS / 2) clk = ~clk;

	////////////////////////////////////////
	// Error handling and checks
	////////////////////////////////////////

	task automatic stop_with_error(input string what);
		$display("ERROR: %s", what);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_with_error("output value differs from the model");
		end
	endtask

	// Elements and done pulses taken on the falling edge
	always @(negedge clk) begin
		nz_elem_t exp_elem;
		if (arst_n && rd_valid) begin
			if (exp_q.size() == 0) begin
				stop_with_error("rd_valid_o high with no element left in the model");
			end else begin
				exp_elem = exp_q.pop_front();
				check_value("rd_elem_o.pos", 32'(rd_elem.pos), 32'(exp_elem.pos));
				check_value("rd_elem_o.data", 32'(rd_elem.data), 32'(exp_elem.data));
				got_cnt++;
			end
		end
		if (arst_n && rd_done) begin
			done_cnt++;
		end
	end

	////////////////////////////////////////
	// Model fill patterns
	////////////////////////////////////////

	// Word 2 stays empty
	task automatic fill_known(input int bank);
		for (int p = 0; p < `MEM_SIZE; p++) begin
			if ((p / 16 != 2) && ((p % 3 == 0) || (p % 7 == 5))) begin
				mem[bank][p] = 8'(p * 3 + 1);
			end else begin
				mem[bank][p] = 8'h00;
			end
		end
	endtask

	task automatic fill_dense(input int bank, input bit nonzero);
		for (int p = 0; p < `MEM_SIZE; p++) begin
			mem[bank][p] = nonzero ? (8'(p) ^ 8'h5a) : 8'h00;
		end
	endtask

	task automatic fill_random(input int bank);
		for (int p = 0; p < `MEM_SIZE; p++) begin
			if ($urandom_range(0, 1) == 1) begin
				mem[bank][p] = 8'($urandom_range(1, 255));
			end else begin
				mem[bank][p] = 8'h00;
			end
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	// Nonzero bytes go to the low lanes and junk fills the rest
	task automatic write_chunk(input int bank);
		chunk_wr_t beat;
		int        lane;
		for (int w = 0; w < `WR_CYC_NUM; w++) begin
			beat            = '0;
			beat.word_count = w[`WR_CNT_W-1:0];
			lane            = 0;
			for (int i = 0; i < `BUS_SIZE; i++) begin
				beat.nonzero_data[i] = 8'($urandom);
			end
			for (int i = 0; i < `BUS_SIZE; i++) begin
				if (mem[bank][w * `BUS_SIZE + i] != 8'h00) begin
					beat.sparsemap[i]       = 1'b1;
					beat.nonzero_data[lane] = mem[bank][w * `BUS_SIZE + i];
					lane++;
				end
			end
			@(negedge clk);
			wr       = beat;
			wr_sel   = bank[0];
			wr_valid = 1'b1;
		end
		@(negedge clk);
		wr_valid = 1'b0;
	endtask

	task automatic run_scan(input int bank);
		nz_elem_t e;
		int       expected_cnt;
		int       start_done;
		int       waited;
		exp_q.delete();
		for (int p = 0; p < `MEM_SIZE; p++) begin
			if (mem[bank][p] != 8'h00) begin
				e.pos  = p[`POS_W-1:0];
				e.data = mem[bank][p];
				exp_q.push_back(e);
			end
		end
		expected_cnt = exp_q.size();
		got_cnt      = 0;
		start_done   = done_cnt;
		@(negedge clk);
		rd_sel      = bank[0];
		chunk_start = 1'b1;
		@(negedge clk);
		chunk_start = 1'b0;
		waited      = 0;
		while (!rd_done && waited < SCAN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!rd_done) begin
			stop_with_error("scan never raised rd_done_o");
		end else begin
			@(negedge clk);
			check_value("rd_done_o", 32'(rd_done), 32'h0);
			check_value("rd_done_o pulses", 32'(done_cnt - start_done), 32'h1);
			check_value("element count", 32'(got_cnt), 32'(expected_cnt));
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	// Idle outputs with no start pulse
	task automatic check_idle_outputs();
		repeat (20) begin
			@(negedge clk);
			check_value("rd_valid_o", 32'(rd_valid), 32'h0);
			check_value("rd_done_o", 32'(rd_done), 32'h0);
		end
	endtask

	task automatic scan_known_pattern();
		fill_known(0);
		write_chunk(0);
		run_scan(0);
	endtask

	task automatic scan_empty_and_full();
		fill_dense(0, 1'b0);
		write_chunk(0);
		run_scan(0);
		fill_dense(1, 1'b1);
		write_chunk(1);
		run_scan(1);
	endtask

	// Bank 1 fills while bank 0 is read
	task automatic scan_ping_pong();
		fill_random(0);
		write_chunk(0);
		fill_known(1);
		fork
			run_scan(0);
			write_chunk(1);
		join
		run_scan(1);
	endtask

	task automatic scan_random_chunks();
		for (int n = 0; n < 10; n++) begin
			fill_random(n % 2);
			write_chunk(n % 2);
			run_scan(n % 2);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(85));
		clk         = 1'b0;
		arst_n      = 1'b0;
		wr          = '0;
		wr_valid    = 1'b0;
		wr_sel      = 1'b0;
		rd_sel      = 1'b0;
		chunk_start = 1'b0;
		got_cnt     = 0;
		done_cnt    = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		check_idle_outputs();
		scan_known_pattern();
		scan_empty_and_full();
		scan_ping_pong();
		scan_random_chunks();

		$display("RESULT: PASS");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		stop_with_error("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire
